//--- hdl/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// ----------------------------------------------------------------------
// buffer geometry
// ----------------------------------------------------------------------
`define ROB_DEPTH 32 // 2**ROB_IDX_W entries
`define ROB_IDX_W 5

// ----------------------------------------------------------------------
// field widths
// ----------------------------------------------------------------------
// physical register tag
`define PRF_TAG_W 6
`define ARCH_REG_W 5 // logical register number
`define BR_MASK_W 4

// free-list head saved per entry
`define FL_HEAD_W 5
`define ADDR_W 64 // branch target

`endif

//--- hdl/rob_pkg.sv
`default_nettype none
`include "rob_params.svh"

package rob_pkg;

	// ----------------------------------------------------------------------
	// entry addressing
	// ----------------------------------------------------------------------
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

	// msb is the wrap bit
	// same index with different wrap means full
	typedef logic [`ROB_IDX_W:0] rob_ptr_t;

	// ----------------------------------------------------------------------
	// payload fields
	// ----------------------------------------------------------------------
	typedef logic [`PRF_TAG_W-1:0] prf_tag_t; // physical tag
	typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [`BR_MASK_W-1:0] br_mask_t; // one bit per open branch

	// free-list head at dispatch time
	typedef logic [`FL_HEAD_W-1:0] fl_head_t;
	typedef logic [`ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

//--- hdl/rob_ptr_if.sv
`timescale 1ns/1ps
`default_nettype none

// allocation and retire strobes from the pointer logic to the entry stores
interface rob_ptr_if;

	logic alloc_en; // write the tail entry this edge
	logic retire_en; // head entry leaves this edge

	rob_pkg::rob_idx_t alloc_idx;
	rob_pkg::rob_idx_t head_idx;

	modport ctrl (
		output alloc_en,
		output alloc_idx,
		output retire_en,
		output head_idx
	);

	// both stores only listen
	modport store (
		input alloc_en,
		input alloc_idx,
		input retire_en,
		input head_idx
	);

endinterface

`default_nettype wire

//--- hdl/rob_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_params.svh"

module rob_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              dispatch_valid_i,
	input  logic              head_done_i,
	input  logic              mispredict_i,
	input  rob_pkg::rob_idx_t br_resolve_idx_i,
	output logic              dispatch_ready_o,
	output logic              retire_valid_o,
	output logic              br_recover_o,
	output rob_pkg::rob_ptr_t rob_tail_o,
	rob_ptr_if.ctrl           ptr
);

	rob_pkg::rob_ptr_t head_r;
	rob_pkg::rob_ptr_t tail_r;
	rob_pkg::rob_ptr_t br_ptr; // full pointer of the resolved branch
	rob_pkg::rob_ptr_t occupancy;
	rob_pkg::rob_idx_t head_idx;
	rob_pkg::rob_idx_t tail_idx;
	logic empty;
	logic full;
	logic alloc;

	assign head_idx = head_r[`ROB_IDX_W-1:0];
	assign tail_idx = tail_r[`ROB_IDX_W-1:0];

	// ----------------------------------------------------------------------
	// status and handshakes
	// ----------------------------------------------------------------------
	assign empty = (head_r == tail_r);
	assign full = (head_idx == tail_idx) && (head_r[`ROB_IDX_W] != tail_r[`ROB_IDX_W]);
	assign occupancy = tail_r - head_r;

	assign retire_valid_o = head_done_i && !empty;
	assign br_recover_o = mispredict_i;

	// a retiring head frees its slot in time for the new entry
	assign dispatch_ready_o = !(full && !retire_valid_o) && !br_recover_o;
	assign alloc = dispatch_valid_i && dispatch_ready_o;

	assign rob_tail_o = tail_r;

	// the branch lies between head and tail, so an index below the head
	// index has already wrapped
	assign br_ptr = {(br_resolve_idx_i < head_idx) ? ~head_r[`ROB_IDX_W] : head_r[`ROB_IDX_W],
		br_resolve_idx_i};

	// ----------------------------------------------------------------------
	// pointer update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (retire_valid_o)
				head_r <= head_r + rob_pkg::rob_ptr_t'(1);
			if (br_recover_o)
				tail_r <= br_ptr + rob_pkg::rob_ptr_t'(1); // drop younger entries
			else if (alloc)
				tail_r <= tail_r + rob_pkg::rob_ptr_t'(1);
		end
	end

	assign ptr.alloc_en = alloc;
	assign ptr.alloc_idx = tail_idx;
	assign ptr.retire_en = retire_valid_o;
	assign ptr.head_idx = head_idx;

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	// the rewound branch must be a live entry so the tail stays ahead of the head
	a_rewind_live: assert property (@(posedge clk) disable iff (rst)
		br_recover_o |-> rob_pkg::rob_ptr_t'(br_ptr - head_r) < occupancy);

endmodule

`default_nettype wire

//--- hdl/rob_entry_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_params.svh"

module rob_entry_store (
	input  logic               clk,
	input  logic               rst,
	rob_ptr_if.store           ptr,
	input  rob_pkg::prf_tag_t  dest_tag_i,
	input  rob_pkg::prf_tag_t  old_tag_i,
	input  rob_pkg::arch_reg_t arch_dest_i,
	input  logic               complete_valid_i,
	input  rob_pkg::rob_idx_t  complete_idx_i,
	output logic               head_done_o,
	output rob_pkg::prf_tag_t  retire_tag_o,
	output rob_pkg::prf_tag_t  retire_old_tag_o,
	output rob_pkg::arch_reg_t retire_arch_dest_o
);

	// ----------------------------------------------------------------------
	// entry storage
	// ----------------------------------------------------------------------
	rob_pkg::prf_tag_t  dest_tag_r  [`ROB_DEPTH]; // new mapping for the arch map
	rob_pkg::prf_tag_t  old_tag_r   [`ROB_DEPTH]; // goes back to the free list
	rob_pkg::arch_reg_t arch_dest_r [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] done_r;

	// payload is only written at dispatch
	always_ff @(posedge clk) begin
		if (ptr.alloc_en) begin
			dest_tag_r[ptr.alloc_idx] <= dest_tag_i;
			old_tag_r[ptr.alloc_idx] <= old_tag_i;
			arch_dest_r[ptr.alloc_idx] <= arch_dest_i;
		end
	end

	// later writes win when done bit indices collide
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= '0;
		end else begin
			if (ptr.retire_en)
				done_r[ptr.head_idx] <= 1'b0;
			if (ptr.alloc_en)
				done_r[ptr.alloc_idx] <= 1'b0; // fresh entry starts pending
			if (complete_valid_i)
				done_r[complete_idx_i] <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// head readout
	// ----------------------------------------------------------------------
	assign head_done_o = done_r[ptr.head_idx];
	assign retire_tag_o = dest_tag_r[ptr.head_idx];
	assign retire_old_tag_o = old_tag_r[ptr.head_idx];
	assign retire_arch_dest_o = arch_dest_r[ptr.head_idx];

	// a unit can only finish an entry that was dispatched in an earlier cycle
	a_no_complete_on_alloc: assert property (@(posedge clk) disable iff (rst)
		complete_valid_i && ptr.alloc_en |-> complete_idx_i != ptr.alloc_idx);

endmodule

`default_nettype wire

//--- hdl/branch_record_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_params.svh"

module branch_record_store (
	input  logic              clk,
	input  logic              rst,
	rob_ptr_if.store          ptr,
	input  logic              br_flag_i,
	input  logic              br_pretaken_i,
	input  rob_pkg::addr_t    br_target_i,
	input  rob_pkg::br_mask_t br_mask_i,
	input  rob_pkg::fl_head_t fl_head_i,
	input  logic              br_resolve_valid_i,
	input  rob_pkg::rob_idx_t br_resolve_idx_i,
	input  logic              br_resolve_taken_i,
	input  rob_pkg::addr_t    br_resolve_target_i,
	output logic              mispredict_o,
	output logic              br_correct_o,
	output rob_pkg::br_mask_t br_mask_o,
	output rob_pkg::fl_head_t fl_recover_head_o
);

	logic [`ROB_DEPTH-1:0] br_flag_r;
	logic [`ROB_DEPTH-1:0] pretaken_r; // predicted direction
	rob_pkg::addr_t    target_r  [`ROB_DEPTH]; // predicted target
	rob_pkg::br_mask_t mask_r    [`ROB_DEPTH];
	rob_pkg::fl_head_t fl_head_r [`ROB_DEPTH];
	logic hit;
	logic wrong;

	// ----------------------------------------------------------------------
	// record update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (ptr.alloc_en) begin
			pretaken_r[ptr.alloc_idx] <= br_pretaken_i;
			target_r[ptr.alloc_idx] <= br_target_i;
			mask_r[ptr.alloc_idx] <= br_mask_i;
			fl_head_r[ptr.alloc_idx] <= fl_head_i;
		end
	end

	// allocation wins when a full buffer retires and refills the same slot
	always_ff @(posedge clk) begin
		if (rst) begin
			br_flag_r <= '0;
		end else begin
			if (ptr.retire_en)
				br_flag_r[ptr.head_idx] <= 1'b0;
			if (ptr.alloc_en)
				br_flag_r[ptr.alloc_idx] <= br_flag_i;
		end
	end

	// ----------------------------------------------------------------------
	// resolution compare
	// ----------------------------------------------------------------------
	assign hit = br_resolve_valid_i && br_flag_r[br_resolve_idx_i];
	assign wrong = (pretaken_r[br_resolve_idx_i] != br_resolve_taken_i) ||
		(target_r[br_resolve_idx_i] != br_resolve_target_i);

	assign mispredict_o = hit && wrong;
	assign br_correct_o = hit && !wrong;
	assign br_mask_o = hit ? mask_r[br_resolve_idx_i] : '0; // freed or squashed mask
	assign fl_recover_head_o = mispredict_o ? fl_head_r[br_resolve_idx_i] : '0;

	// the branch unit resolves only entries dispatched as branches
	a_resolve_is_branch: assert property (@(posedge clk) disable iff (rst)
		br_resolve_valid_i |-> br_flag_r[br_resolve_idx_i]);

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
	input  logic               clk,
	input  logic               rst,
	// dispatch
	input  logic               dispatch_valid_i,
	output logic               dispatch_ready_o,
	output rob_pkg::rob_ptr_t  rob_tail_o,
	input  rob_pkg::prf_tag_t  dest_tag_i,
	input  rob_pkg::prf_tag_t  old_tag_i,
	input  rob_pkg::arch_reg_t arch_dest_i,
	input  logic               br_flag_i,
	input  logic               br_pretaken_i,
	input  rob_pkg::addr_t     br_target_i,
	input  rob_pkg::br_mask_t  br_mask_i,
	input  rob_pkg::fl_head_t  fl_head_i,
	// completion
	input  logic               complete_valid_i,
	input  rob_pkg::rob_idx_t  complete_idx_i,
	// retire
	output logic               retire_valid_o,
	output rob_pkg::prf_tag_t  retire_tag_o,
	output rob_pkg::prf_tag_t  retire_old_tag_o,
	output rob_pkg::arch_reg_t retire_arch_dest_o,
	// branch resolution
	input  logic               br_resolve_valid_i,
	input  rob_pkg::rob_idx_t  br_resolve_idx_i,
	input  logic               br_resolve_taken_i,
	input  rob_pkg::addr_t     br_resolve_target_i,
	output logic               br_recover_o,
	output logic               br_correct_o,
	output rob_pkg::br_mask_t  br_mask_o,
	output rob_pkg::fl_head_t  fl_recover_head_o
);

	logic head_done;
	logic mispredict;

	rob_ptr_if ptr_if ();

	rob_ctrl ctrl0 (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.head_done_i      (head_done),
		.mispredict_i     (mispredict),
		.br_resolve_idx_i (br_resolve_idx_i),
		.dispatch_ready_o (dispatch_ready_o),
		.retire_valid_o   (retire_valid_o),
		.br_recover_o     (br_recover_o),
		.rob_tail_o       (rob_tail_o),
		.ptr              (ptr_if.ctrl)
	);

	rob_entry_store entries0 (
		.clk                (clk),
		.rst                (rst),
		.ptr                (ptr_if.store),
		.dest_tag_i         (dest_tag_i),
		.old_tag_i          (old_tag_i),
		.arch_dest_i        (arch_dest_i),
		.complete_valid_i   (complete_valid_i),
		.complete_idx_i     (complete_idx_i),
		.head_done_o        (head_done),
		.retire_tag_o       (retire_tag_o),
		.retire_old_tag_o   (retire_old_tag_o),
		.retire_arch_dest_o (retire_arch_dest_o)
	);

	branch_record_store branches0 (
		.clk                 (clk),
		.rst                 (rst),
		.ptr                 (ptr_if.store),
		.br_flag_i           (br_flag_i),
		.br_pretaken_i       (br_pretaken_i),
		.br_target_i         (br_target_i),
		.br_mask_i           (br_mask_i),
		.fl_head_i           (fl_head_i),
		.br_resolve_valid_i  (br_resolve_valid_i),
		.br_resolve_idx_i    (br_resolve_idx_i),
		.br_resolve_taken_i  (br_resolve_taken_i),
		.br_resolve_target_i (br_resolve_target_i),
		.mispredict_o        (mispredict),
		.br_correct_o        (br_correct_o),
		.br_mask_o           (br_mask_o),
		.fl_recover_head_o   (fl_recover_head_o)
	);

endmodule

`default_nettype wire

//--- sim/tb_rob.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_params.svh"

module tb_rob;

	typedef struct packed {
		rob_pkg::rob_ptr_t  ptr;
		rob_pkg::prf_tag_t  dest;
		rob_pkg::prf_tag_t  old;
		rob_pkg::arch_reg_t arch;
		logic               done;
	} entry_t;

	logic clk = 1'b0;
	logic rst;
	logic dispatch_valid_i, dispatch_ready_o;
	rob_pkg::rob_ptr_t rob_tail_o;
	rob_pkg::prf_tag_t dest_tag_i, old_tag_i, retire_tag_o, retire_old_tag_o;
	rob_pkg::arch_reg_t arch_dest_i, retire_arch_dest_o;
	logic br_flag_i, br_pretaken_i;
	rob_pkg::addr_t br_target_i, br_resolve_target_i;
	rob_pkg::br_mask_t br_mask_i, br_mask_o;
	rob_pkg::fl_head_t fl_head_i, fl_recover_head_o;
	logic complete_valid_i;
	rob_pkg::rob_idx_t complete_idx_i, br_resolve_idx_i;
	logic retire_valid_o;
	logic br_resolve_valid_i, br_resolve_taken_i, br_recover_o, br_correct_o;

	int errors = 0;
	int tests_run = 0;
	logic timed_out = 1'b0;

	rob_top dut0 (.*);

	always #10 clk = ~clk; // 20 ns period

	// ----------------------------------------------------------------------
	// reference model with entries kept in dispatch order
	// ----------------------------------------------------------------------
	entry_t q[$];
	entry_t exp_head;
	int exp_count = 0;
	logic exp_head_done = 1'b0;
	rob_pkg::rob_ptr_t exp_tail = '0;
	logic [`ROB_DEPTH-1:0] mdl_br = '0;
	logic [`ROB_DEPTH-1:0] mdl_taken;
	rob_pkg::addr_t mdl_target [`ROB_DEPTH];
	rob_pkg::br_mask_t mdl_mask [`ROB_DEPTH];
	rob_pkg::fl_head_t mdl_fl [`ROB_DEPTH];
	logic exp_retire, exp_wrong, exp_recover, exp_ready;

	assign exp_retire = (exp_count != 0) && exp_head_done;
	assign exp_wrong = (mdl_taken[br_resolve_idx_i] != br_resolve_taken_i) ||
		(mdl_target[br_resolve_idx_i] != br_resolve_target_i);
	assign exp_recover = br_resolve_valid_i && mdl_br[br_resolve_idx_i] && exp_wrong;
	assign exp_ready = !(exp_count == `ROB_DEPTH && !exp_retire) && !exp_recover;

	always @(posedge clk) begin : model
		int k;
		if (rst) begin
			q.delete();
			exp_tail <= '0;
		end else begin
			if (complete_valid_i)
				foreach (q[i])
					if (q[i].ptr[`ROB_IDX_W-1:0] == complete_idx_i)
						q[i].done = 1'b1;
			if (exp_recover) begin
				k = 0;
				foreach (q[i])
					if (q[i].ptr[`ROB_IDX_W-1:0] == br_resolve_idx_i)
						k = i;
				while (q.size() > k + 1)
					void'(q.pop_back()); // younger entries are gone
				exp_tail <= q[k].ptr + 1'b1;
			end
			if (exp_retire)
				void'(q.pop_front());
			if (dispatch_valid_i && exp_ready) begin
				q.push_back(entry_t'{exp_tail, dest_tag_i, old_tag_i, arch_dest_i, 1'b0});
				mdl_br[exp_tail[`ROB_IDX_W-1:0]] <= br_flag_i;
				mdl_taken[exp_tail[`ROB_IDX_W-1:0]] <= br_pretaken_i;
				mdl_target[exp_tail[`ROB_IDX_W-1:0]] <= br_target_i;
				mdl_mask[exp_tail[`ROB_IDX_W-1:0]] <= br_mask_i;
				mdl_fl[exp_tail[`ROB_IDX_W-1:0]] <= fl_head_i;
				exp_tail <= exp_tail + 1'b1;
			end
		end
		exp_count <= q.size();
		exp_head_done <= (q.size() != 0) ? q[0].done : 1'b0;
		if (q.size() != 0)
			exp_head <= q[0];
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic report_mismatch(input string what);
		errors++;
		$display("MISMATCH at %0t: %s", $time, what);
	endtask

	a_reset_state: assert property (@(posedge clk) $fell(rst) |-> dispatch_ready_o &&
		!retire_valid_o && !br_recover_o && !br_correct_o && rob_tail_o == '0)
		else report_mismatch("state after reset");

	a_retire_valid: assert property (@(posedge clk) disable iff (rst)
		retire_valid_o == exp_retire)
		else report_mismatch("retire strobe");

	a_retire_data: assert property (@(posedge clk) disable iff (rst)
		retire_valid_o |-> retire_tag_o == exp_head.dest &&
		retire_old_tag_o == exp_head.old && retire_arch_dest_o == exp_head.arch)
		else report_mismatch("retire data");

	a_ready: assert property (@(posedge clk) disable iff (rst) dispatch_ready_o == exp_ready)
		else report_mismatch("dispatch ready");

	a_tail: assert property (@(posedge clk) disable iff (rst) rob_tail_o == exp_tail)
		else report_mismatch("tail pointer");

	// same-cycle outcome of a resolution
	a_resolve: assert property (@(posedge clk) disable iff (rst)
		br_correct_o == (br_resolve_valid_i && mdl_br[br_resolve_idx_i] && !exp_wrong) &&
		br_recover_o == exp_recover)
		else report_mismatch("branch outcome");

	a_resolve_mask: assert property (@(posedge clk) disable iff (rst)
		br_resolve_valid_i |-> br_mask_o == mdl_mask[br_resolve_idx_i])
		else report_mismatch("branch mask");

	a_recover_head: assert property (@(posedge clk) disable iff (rst)
		fl_recover_head_o == (exp_recover ? mdl_fl[br_resolve_idx_i] : '0))
		else report_mismatch("free-list head");

	a_rewind: assert property (@(posedge clk) disable iff (rst) br_recover_o |=>
		rob_tail_o[`ROB_IDX_W-1:0] == rob_pkg::rob_idx_t'($past(br_resolve_idx_i) + 1'b1))
		else report_mismatch("tail rewind");

	// ----------------------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------------------
	rob_pkg::rob_idx_t pend[$]; // indices still waiting to complete

	task automatic next_cycle();
		@(posedge clk);
		#2;
		complete_valid_i = 1'b0;
		br_resolve_valid_i = 1'b0;
	endtask

	task automatic dispatch_one(input logic br, input logic taken, input rob_pkg::addr_t target,
		input rob_pkg::br_mask_t mask, input rob_pkg::fl_head_t fl);
		int n;
		logic ok;
		dispatch_valid_i = 1'b1;
		dest_tag_i = rob_pkg::prf_tag_t'($urandom);
		old_tag_i = rob_pkg::prf_tag_t'($urandom);
		arch_dest_i = rob_pkg::arch_reg_t'($urandom);
		br_flag_i = br;
		br_pretaken_i = taken;
		br_target_i = target;
		br_mask_i = mask;
		fl_head_i = fl;
		ok = 1'b0;
		for (n = 0; n < 100 && !ok; n++) begin
			#1; // ready is settled here
			ok = dispatch_ready_o;
			if (ok)
				pend.push_back(exp_tail[`ROB_IDX_W-1:0]);
			next_cycle();
		end
		dispatch_valid_i = 1'b0;
		if (!ok) begin
			timed_out = 1'b1;
			$display("timeout: dispatch was never accepted");
		end
	endtask

	task automatic resolve(input rob_pkg::rob_idx_t idx, input logic taken,
		input rob_pkg::addr_t target);
		br_resolve_valid_i = 1'b1;
		br_resolve_idx_i = idx;
		br_resolve_taken_i = taken;
		br_resolve_target_i = target;
		next_cycle();
	endtask

	task automatic wait_empty();
		int n;
		for (n = 0; n < 200 && exp_count != 0; n++)
			next_cycle();
		if (exp_count != 0) begin
			timed_out = 1'b1;
			$display("timeout: buffer did not drain");
		end
	endtask

	// finish every pending entry in shuffled order and drain
	task automatic complete_all();
		int i;
		int j;
		rob_pkg::rob_idx_t tmp;
		for (i = pend.size() - 1; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			tmp = pend[i];
			pend[i] = pend[j];
			pend[j] = tmp;
		end
		foreach (pend[k]) begin
			complete_valid_i = 1'b1;
			complete_idx_i = pend[k];
			next_cycle();
		end
		pend.delete();
		wait_empty();
	endtask

	task automatic test_done(input string name);
		tests_run++;
		$display("test %0d %s done, errors so far %0d", tests_run, name, errors);
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		rob_pkg::addr_t tgt;
		rob_pkg::br_mask_t m;
		rob_pkg::fl_head_t f;
		rob_pkg::rob_idx_t bi;
		void'($urandom(32'h2a60));
		rst = 1'b1;
		dispatch_valid_i = 1'b0;
		dest_tag_i = '0;
		old_tag_i = '0;
		arch_dest_i = '0;
		br_flag_i = 1'b0;
		br_pretaken_i = 1'b0;
		br_target_i = '0;
		br_mask_i = '0;
		fl_head_i = '0;
		complete_valid_i = 1'b0;
		complete_idx_i = '0;
		br_resolve_valid_i = 1'b0;
		br_resolve_idx_i = '0;
		br_resolve_taken_i = 1'b0;
		br_resolve_target_i = '0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		next_cycle();
		next_cycle();
		test_done("reset");

		if (!timed_out) begin
			repeat (8 + $urandom % 8)
				dispatch_one(1'b0, 1'b0, '0, '0, '0);
			complete_all();
			test_done("shuffled completion");
		end

		if (!timed_out) begin
			repeat (`ROB_DEPTH)
				dispatch_one(1'b0, 1'b0, '0, '0, '0);
			complete_valid_i = 1'b1; // head done while one more entry waits
			complete_idx_i = pend[0];
			void'(pend.pop_front());
			dispatch_one(1'b0, 1'b0, '0, '0, '0);
			complete_all();
			test_done("full buffer");
		end

		if (!timed_out) begin
			tgt = {$urandom, $urandom};
			m = rob_pkg::br_mask_t'($urandom | 1);
			f = rob_pkg::fl_head_t'($urandom);
			dispatch_one(1'b1, 1'b1, tgt, m, f);
			bi = pend[pend.size() - 1];
			dispatch_one(1'b0, 1'b0, '0, '0, '0);
			dispatch_one(1'b0, 1'b0, '0, '0, '0);
			resolve(bi, 1'b1, tgt);
			complete_all();
			test_done("correct prediction");
		end

		// round 0 misses the target and round 1 the direction
		for (int r = 0; r < 2 && !timed_out; r++) begin
			tgt = {$urandom, $urandom};
			m = rob_pkg::br_mask_t'($urandom | 1);
			f = rob_pkg::fl_head_t'($urandom);
			dispatch_one(1'b1, r == 0, tgt, m, f);
			bi = pend[pend.size() - 1];
			repeat (3)
				dispatch_one(1'b0, 1'b0, '0, '0, '0);
			if (r == 0)
				resolve(bi, 1'b1, tgt ^ 64'h40);
			else
				resolve(bi, 1'b1, tgt);
			while (pend.size() > 1)
				void'(pend.pop_back());
			complete_all();
			test_done(r == 0 ? "target mispredict" : "direction mispredict");
		end

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0 && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_ptr_if.sv
hdl/rob_ctrl.sv
hdl/rob_entry_store.sv
hdl/branch_record_store.sv
hdl/rob_top.sv
sim/tb_rob.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
